// ==== ad_cfg_pkg.sv ====
// geometry is fixed at 256-bit lines over 64-bit beats; single requests travel in word 0
`default_nettype none

package ad_cfg_pkg;

  // --------------------------------------------------
  // line geometry
  // --------------------------------------------------
  localparam int unsigned LINE_WIDTH    = 256;
  localparam int unsigned BEAT_WIDTH    = 64;
  localparam int unsigned BEATS         = LINE_WIDTH / BEAT_WIDTH;
  localparam int unsigned BEAT_IDX_W    = $clog2(BEATS);
  localparam int unsigned ADDR_WIDTH    = 32;
  localparam int unsigned ID_WIDTH      = 4;
  localparam int unsigned LINE_OFFSET_W = $clog2(LINE_WIDTH / 8);
  localparam int unsigned BEAT_OFFSET_W = $clog2(BEAT_WIDTH / 8);

  typedef logic [BEAT_IDX_W-1:0] beat_idx_t;

  // index of the final beat of a line
  localparam beat_idx_t LAST_BEAT = beat_idx_t'(BEATS - 1);

  // --------------------------------------------------
  // cache side request and response
  // --------------------------------------------------
  typedef enum logic {
    REQ_SINGLE = 1'b0,
    REQ_LINE   = 1'b1
  } req_kind_e;

  typedef logic [BEATS-1:0][BEAT_WIDTH-1:0]   line_t;
  typedef logic [BEATS-1:0][BEAT_WIDTH/8-1:0] strb_line_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  we;
    req_kind_e             kind;
    // axi size code where bytes = 2**size
    logic [2:0]            size;
    logic [ID_WIDTH-1:0]   id;
    line_t                 wdata;
    strb_line_t            wstrb;
  } ad_req_t;

  typedef struct packed {
    logic                valid;
    logic [ID_WIDTH-1:0] id;
    line_t               data;
  } ad_rsp_t;

endpackage

`default_nettype wire

// ==== ad_axi_pkg.sv ====
// AXI4 subset without user, region, qos, prot, lock or atop; widths follow ad_cfg_pkg
`default_nettype none

package ad_axi_pkg;

  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;
  typedef logic [3:0] cache_t;
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;

  typedef logic [ad_cfg_pkg::ADDR_WIDTH-1:0]   addr_t;
  typedef logic [ad_cfg_pkg::ID_WIDTH-1:0]     id_t;
  typedef logic [ad_cfg_pkg::BEAT_WIDTH-1:0]   data_t;
  typedef logic [ad_cfg_pkg::BEAT_WIDTH/8-1:0] strb_t;

  // --------------------------------------------------
  // encodings
  // --------------------------------------------------
  localparam burst_t BURST_INCR       = 2'b01;
  localparam resp_t  RESP_OKAY        = 2'b00;
  localparam cache_t CACHE_MODIFIABLE = 4'b0010;

  // burst shape of a whole line
  localparam len_t  LEN_LINE  = len_t'(ad_cfg_pkg::BEATS - 1);
  localparam size_t SIZE_BEAT = size_t'(ad_cfg_pkg::BEAT_OFFSET_W);

  // --------------------------------------------------
  // channels
  // --------------------------------------------------
  // AW and AR carry the same fields
  typedef struct packed {
    addr_t  addr;
    id_t    id;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
  } ax_chan_t;

  typedef ax_chan_t aw_chan_t;
  typedef ax_chan_t ar_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    resp_t resp;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
    logic    r_valid;
    r_chan_t r;
  } axi_rsp_t;

endpackage

`default_nettype wire

// ==== ad_write_ctrl.sv ====
// req_data_i must stay stable until gnt_o; line writes start at the line base and singles send word 0
`timescale 1ns/1ps
`default_nettype none

module ad_write_ctrl (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  req_i,
  input  wire ad_cfg_pkg::ad_req_t   req_data_i,
  output logic                       gnt_o,
  output ad_cfg_pkg::ad_rsp_t        rsp_o,
  output logic                       busy_o,
  output ad_axi_pkg::aw_chan_t       aw_o,
  output logic                       aw_valid_o,
  input  wire logic                  aw_ready_i,
  output ad_axi_pkg::w_chan_t        w_o,
  output logic                       w_valid_o,
  input  wire logic                  w_ready_i,
  input  wire ad_axi_pkg::b_chan_t   b_i,
  input  wire logic                  b_valid_i,
  output logic                       b_ready_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_AW,
    WAIT_LAST_W,
    WAIT_BOTH,
    WAIT_AW_BURST,
    WAIT_B
  } state_e;

  state_e                state_q, state_d;
  // beats still to send after the one on the bus
  ad_cfg_pkg::beat_idx_t cnt_q, cnt_d;
  ad_cfg_pkg::beat_idx_t w_idx;
  logic                  is_line;

  assign is_line = (req_data_i.kind == ad_cfg_pkg::REQ_LINE);
  assign busy_o  = (state_q != IDLE);

  // word on W counts up while cnt_q counts down
  assign w_idx = (is_line && state_q != IDLE) ? ad_cfg_pkg::LAST_BEAT - cnt_q : '0;

  // --------------------------------------------------
  // channel payload
  // --------------------------------------------------
  always_comb begin
    aw_o.addr  = req_data_i.addr;
    aw_o.id    = req_data_i.id;
    aw_o.len   = '0;
    aw_o.size  = req_data_i.size;
    aw_o.burst = ad_axi_pkg::BURST_INCR;
    aw_o.cache = ad_axi_pkg::CACHE_MODIFIABLE;
    if (is_line) begin
      aw_o.addr = {req_data_i.addr[ad_cfg_pkg::ADDR_WIDTH-1:ad_cfg_pkg::LINE_OFFSET_W],
                   {ad_cfg_pkg::LINE_OFFSET_W{1'b0}}};
      aw_o.len  = ad_axi_pkg::LEN_LINE;
      aw_o.size = ad_axi_pkg::SIZE_BEAT;
    end

    w_o.data = req_data_i.wdata[w_idx];
    w_o.strb = req_data_i.wstrb[w_idx];
    // in idle the first beat is also the last one only for a single write
    w_o.last = (state_q == IDLE) ? !is_line : (cnt_q == '0);
  end

  // --------------------------------------------------
  // handshake FSM
  // --------------------------------------------------
  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    b_ready_o  = 1'b0;
    gnt_o      = 1'b0;
    rsp_o      = '0;

    case (state_q)
      IDLE: begin
        if (req_i) begin
          aw_valid_o = 1'b1;
          w_valid_o  = 1'b1;
          if (!is_line) begin
            cnt_d = '0;
            gnt_o = aw_ready_i & w_ready_i;
            case ({aw_ready_i, w_ready_i})
              2'b11:   state_d = WAIT_B;
              2'b10:   state_d = WAIT_LAST_W;
              2'b01:   state_d = WAIT_AW;
              default: state_d = IDLE;
            endcase
          end else begin
            cnt_d = w_ready_i ? ad_cfg_pkg::LAST_BEAT - 1'b1 : ad_cfg_pkg::LAST_BEAT;
            if (aw_ready_i) begin
              state_d = WAIT_LAST_W;
            end else if (w_ready_i) begin
              state_d = WAIT_BOTH;
            end
          end
        end
      end

      // all data is out, only the address is pending
      WAIT_AW, WAIT_AW_BURST: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          gnt_o   = 1'b1;
          state_d = WAIT_B;
        end
      end

      WAIT_LAST_W: begin
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          if (cnt_q == '0) begin
            gnt_o   = 1'b1;
            state_d = WAIT_B;
          end else begin
            cnt_d = cnt_q - 1'b1;
          end
        end
      end

      // line write with both the address and some beats outstanding
      WAIT_BOTH: begin
        aw_valid_o = 1'b1;
        w_valid_o  = 1'b1;
        case ({aw_ready_i, w_ready_i})
          2'b11: begin
            if (cnt_q == '0) begin
              gnt_o   = 1'b1;
              state_d = WAIT_B;
            end else begin
              cnt_d   = cnt_q - 1'b1;
              state_d = WAIT_LAST_W;
            end
          end
          2'b10: state_d = WAIT_LAST_W;
          2'b01: begin
            if (cnt_q == '0) begin
              state_d = WAIT_AW_BURST;
            end else begin
              cnt_d = cnt_q - 1'b1;
            end
          end
          default: state_d = WAIT_BOTH;
        endcase
      end

      WAIT_B: begin
        b_ready_o = b_valid_i;
        if (b_valid_i) begin
          rsp_o.valid = 1'b1;
          rsp_o.id    = b_i.id;
          state_d     = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

`default_nettype wire

// ==== ad_read_ctrl.sv ====
// line reads use INCR from the line base; a single read fills word 0 and keeps the other words
`timescale 1ns/1ps
`default_nettype none

module ad_read_ctrl (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          req_i,
  input  wire ad_cfg_pkg::ad_req_t           req_data_i,
  output logic                               gnt_o,
  output ad_cfg_pkg::ad_rsp_t                rsp_o,
  output logic                               busy_o,
  output logic                               crit_valid_o,
  output logic [ad_cfg_pkg::BEAT_WIDTH-1:0]  crit_word_o,
  output ad_axi_pkg::ar_chan_t               ar_o,
  output logic                               ar_valid_o,
  input  wire logic                          ar_ready_i,
  input  wire ad_axi_pkg::r_chan_t           r_i,
  input  wire logic                          r_valid_i,
  output logic                               r_ready_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_R_SINGLE,
    WAIT_R_LINE,
    COMPLETE
  } state_e;

  state_e                state_q, state_d;
  // index of the next beat to arrive
  ad_cfg_pkg::beat_idx_t cnt_q, cnt_d;
  // beat that holds the requested address
  ad_cfg_pkg::beat_idx_t offset_q, offset_d;
  ad_axi_pkg::id_t       id_q, id_d;
  ad_cfg_pkg::line_t     line_q, line_d;
  logic                  is_line;

  assign is_line = (req_data_i.kind == ad_cfg_pkg::REQ_LINE);
  assign busy_o  = (state_q != IDLE);

  // --------------------------------------------------
  // read address
  // --------------------------------------------------
  always_comb begin
    ar_o.addr  = req_data_i.addr;
    ar_o.id    = req_data_i.id;
    ar_o.len   = '0;
    ar_o.size  = req_data_i.size;
    ar_o.burst = ad_axi_pkg::BURST_INCR;
    ar_o.cache = ad_axi_pkg::CACHE_MODIFIABLE;
    if (is_line) begin
      ar_o.addr = {req_data_i.addr[ad_cfg_pkg::ADDR_WIDTH-1:ad_cfg_pkg::LINE_OFFSET_W],
                   {ad_cfg_pkg::LINE_OFFSET_W{1'b0}}};
      ar_o.len  = ad_axi_pkg::LEN_LINE;
      ar_o.size = ad_axi_pkg::SIZE_BEAT;
    end
  end

  // --------------------------------------------------
  // read FSM
  // --------------------------------------------------
  always_comb begin
    state_d      = state_q;
    cnt_d        = cnt_q;
    offset_d     = offset_q;
    id_d         = id_q;
    line_d       = line_q;
    ar_valid_o   = 1'b0;
    r_ready_o    = 1'b0;
    gnt_o        = 1'b0;
    rsp_o        = '0;
    crit_valid_o = 1'b0;
    crit_word_o  = r_i.data;

    case (state_q)
      IDLE: begin
        if (req_i) begin
          ar_valid_o = 1'b1;
          gnt_o      = ar_ready_i;
          cnt_d      = '0;
          if (ar_ready_i) begin
            offset_d = req_data_i.addr[ad_cfg_pkg::BEAT_OFFSET_W +: ad_cfg_pkg::BEAT_IDX_W];
            state_d  = is_line ? WAIT_R_LINE : WAIT_R_SINGLE;
          end
        end
      end

      WAIT_R_SINGLE, WAIT_R_LINE: begin
        r_ready_o = 1'b1;
        if (r_valid_i) begin
          if (state_q == WAIT_R_LINE) begin
            line_d[cnt_q] = r_i.data;
            // bursts start at the line base so beat k is word k
            crit_valid_o  = (cnt_q == offset_q);
          end else begin
            line_d[0] = r_i.data;
          end
          cnt_d = cnt_q + 1'b1;
          if (r_i.last) begin
            id_d    = r_i.id;
            state_d = COMPLETE;
          end
        end
      end

      COMPLETE: begin
        rsp_o.valid = 1'b1;
        rsp_o.id    = id_q;
        rsp_o.data  = line_q;
        state_d     = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      cnt_q    <= '0;
      offset_q <= '0;
    end else begin
      state_q  <= state_d;
      cnt_q    <= cnt_d;
      offset_q <= offset_d;
    end
  end

  // assembled line and returned id
  always_ff @(posedge clk_i) begin
    line_q <= line_d;
    id_q   <= id_d;
  end

endmodule

`default_nettype wire

// ==== axi_line_adapter.sv ====
// one transaction at a time; a request waits while the opposite path is still busy
`timescale 1ns/1ps
`default_nettype none

module axi_line_adapter (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          req_i,
  input  wire ad_cfg_pkg::ad_req_t           req_data_i,
  output logic                               gnt_o,
  output ad_cfg_pkg::ad_rsp_t                rsp_o,
  output logic                               crit_valid_o,
  output logic [ad_cfg_pkg::BEAT_WIDTH-1:0]  crit_word_o,
  output logic                               busy_o,
  output ad_axi_pkg::axi_req_t               axi_req_o,
  input  wire ad_axi_pkg::axi_rsp_t          axi_rsp_i
);

  logic                 wr_req, rd_req;
  logic                 wr_gnt, rd_gnt;
  logic                 wr_busy, rd_busy;
  ad_cfg_pkg::ad_rsp_t  wr_rsp, rd_rsp;
  ad_axi_pkg::aw_chan_t wr_aw;
  ad_axi_pkg::w_chan_t  wr_w;
  ad_axi_pkg::ar_chan_t rd_ar;
  logic                 wr_aw_valid, wr_w_valid, wr_b_ready;
  logic                 rd_ar_valid, rd_r_ready;

  // --------------------------------------------------
  // steering
  // --------------------------------------------------
  assign wr_req = req_i &  req_data_i.we & ~rd_busy;
  assign rd_req = req_i & ~req_data_i.we & ~wr_busy;

  ad_write_ctrl u_write_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (wr_req),
    .req_data_i (req_data_i),
    .gnt_o      (wr_gnt),
    .rsp_o      (wr_rsp),
    .busy_o     (wr_busy),
    .aw_o       (wr_aw),
    .aw_valid_o (wr_aw_valid),
    .aw_ready_i (axi_rsp_i.aw_ready),
    .w_o        (wr_w),
    .w_valid_o  (wr_w_valid),
    .w_ready_i  (axi_rsp_i.w_ready),
    .b_i        (axi_rsp_i.b),
    .b_valid_i  (axi_rsp_i.b_valid),
    .b_ready_o  (wr_b_ready)
  );

  ad_read_ctrl u_read_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (rd_req),
    .req_data_i   (req_data_i),
    .gnt_o        (rd_gnt),
    .rsp_o        (rd_rsp),
    .busy_o       (rd_busy),
    .crit_valid_o (crit_valid_o),
    .crit_word_o  (crit_word_o),
    .ar_o         (rd_ar),
    .ar_valid_o   (rd_ar_valid),
    .ar_ready_i   (axi_rsp_i.ar_ready),
    .r_i          (axi_rsp_i.r),
    .r_valid_i    (axi_rsp_i.r_valid),
    .r_ready_o    (rd_r_ready)
  );

  // --------------------------------------------------
  // merge
  // --------------------------------------------------
  always_comb begin
    axi_req_o.aw       = wr_aw;
    axi_req_o.aw_valid = wr_aw_valid;
    axi_req_o.w        = wr_w;
    axi_req_o.w_valid  = wr_w_valid;
    axi_req_o.b_ready  = wr_b_ready;
    axi_req_o.ar       = rd_ar;
    axi_req_o.ar_valid = rd_ar_valid;
    axi_req_o.r_ready  = rd_r_ready;
  end

  // an idle path drives an all-zero response, so OR is enough
  assign rsp_o  = wr_rsp | rd_rsp;
  assign gnt_o  = wr_gnt | rd_gnt;
  assign busy_o = wr_busy | rd_busy;

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
// 64-word AXI4 slave model; one write and one read outstanding; addresses wrap at 512 bytes
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire ad_axi_pkg::axi_req_t axi_req_i,
  output ad_axi_pkg::axi_rsp_t      axi_rsp_o
);

  logic [ad_cfg_pkg::BEAT_WIDTH-1:0] mem [64];

  ad_axi_pkg::axi_rsp_t rsp = '0;

  // write side state
  logic                aw_pend = 1'b0;
  logic                w_done  = 1'b0;
  logic [5:0]          aw_idx;
  ad_axi_pkg::id_t     aw_id;
  ad_axi_pkg::w_chan_t w_q[$];

  // read side state
  logic                ar_pend = 1'b0;
  logic [5:0]          ar_idx;
  ad_axi_pkg::id_t     ar_id;
  ad_axi_pkg::len_t    ar_len;
  ad_axi_pkg::len_t    r_beat;

  assign axi_rsp_o = rsp;

  // roughly two cycles in three move
  function automatic logic not_stalled();
    return ($urandom % 3) != 0;
  endfunction

  // --------------------------------------------------
  // handshakes sampled at the edge and outputs driven 1 ns later
  // --------------------------------------------------
  always @(posedge clk_i) begin
    logic                 aw_fire, w_fire, b_fire, ar_fire, r_fire;
    ad_axi_pkg::aw_chan_t aw_s;
    ad_axi_pkg::ar_chan_t ar_s;
    ad_axi_pkg::w_chan_t  w_s;
    logic [5:0]           idx;
    aw_fire = axi_req_i.aw_valid && rsp.aw_ready;
    w_fire  = axi_req_i.w_valid && rsp.w_ready;
    b_fire  = axi_req_i.b_ready && rsp.b_valid;
    ar_fire = axi_req_i.ar_valid && rsp.ar_ready;
    r_fire  = axi_req_i.r_ready && rsp.r_valid;
    aw_s    = axi_req_i.aw;
    ar_s    = axi_req_i.ar;
    w_s     = axi_req_i.w;
    #1;
    if (!rst_ni) begin
      rsp     = '0;
      aw_pend = 1'b0;
      w_done  = 1'b0;
      ar_pend = 1'b0;
      w_q.delete();
    end else begin
      if (aw_fire) begin
        aw_pend = 1'b1;
        aw_idx  = aw_s.addr[8:3];
        aw_id   = aw_s.id;
      end
      if (w_fire) begin
        w_q.push_back(w_s);
        w_done = w_s.last;
      end
      if (b_fire) rsp.b_valid = 1'b0;
      // commit the burst once address and last beat are both in
      if (aw_pend && w_done && !rsp.b_valid && not_stalled()) begin
        foreach (w_q[k]) begin
          idx = aw_idx + 6'(k);
          for (int b = 0; b < 8; b++) begin
            if (w_q[k].strb[b]) mem[idx][8*b +: 8] = w_q[k].data[8*b +: 8];
          end
        end
        rsp.b_valid = 1'b1;
        rsp.b.id    = aw_id;
        rsp.b.resp  = ad_axi_pkg::RESP_OKAY;
        aw_pend     = 1'b0;
        w_done      = 1'b0;
        w_q.delete();
      end
      rsp.aw_ready = !aw_pend && not_stalled();
      rsp.w_ready  = !w_done && not_stalled();

      if (ar_fire) begin
        ar_pend = 1'b1;
        ar_idx  = ar_s.addr[8:3];
        ar_id   = ar_s.id;
        ar_len  = ar_s.len;
        r_beat  = '0;
      end
      if (r_fire) begin
        rsp.r_valid = 1'b0;
        if (rsp.r.last) ar_pend = 1'b0;
        else r_beat = r_beat + 1'b1;
      end
      if (ar_pend && !rsp.r_valid && not_stalled()) begin
        idx         = ar_idx + r_beat[5:0];
        rsp.r_valid = 1'b1;
        rsp.r.data  = mem[idx];
        rsp.r.id    = ar_id;
        rsp.r.resp  = ad_axi_pkg::RESP_OKAY;
        rsp.r.last  = (r_beat == ar_len);
      end
      rsp.ar_ready = !ar_pend && not_stalled();
    end
  end

endmodule

`default_nettype wire

// ==== tb_axi_line_adapter.sv ====
// one request in flight at a time; memory model holds 64 words, so addresses use bits [8:0]
`timescale 1ns/1ps
`default_nettype none

module tb_axi_line_adapter;

  localparam int unsigned N_DIRECTED   = 5;
  localparam int unsigned N_RANDOM     = 40;
  localparam int unsigned N_TRANS      = N_DIRECTED + N_RANDOM;
  localparam int unsigned DRAIN_CYCLES = 20;
  // 40 cycles per transaction on top of the reset and the final drain
  localparam int unsigned MAX_CYCLES   = 40 * N_TRANS + 8 + DRAIN_CYCLES;

  typedef struct packed {
    logic        we;
    logic        is_line;
    logic [31:0] addr;
    logic [3:0]  id;
  } txn_t;

  logic                              clk_i;
  logic                              rst_ni;
  logic                              req;
  ad_cfg_pkg::ad_req_t               req_data;
  logic                              gnt;
  ad_cfg_pkg::ad_rsp_t               rsp;
  logic                              crit_valid;
  logic [ad_cfg_pkg::BEAT_WIDTH-1:0] crit_word;
  logic                              busy;
  ad_axi_pkg::axi_req_t              axi_req;
  ad_axi_pkg::axi_rsp_t              axi_rsp;

  logic [ad_cfg_pkg::BEAT_WIDTH-1:0] shadow [64];
  txn_t                              pend_q[$];
  txn_t                              cur_txn;
  ad_cfg_pkg::line_t                 prev_line;
  logic                              have_prev  = 1'b0;
  logic                              in_flight  = 1'b0;
  int unsigned                       rsp_count  = 0;
  int unsigned                       crit_count = 0;
  int unsigned                       cycles     = 0;

  axi_line_adapter u_axi_line_adapter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req),
    .req_data_i   (req_data),
    .gnt_o        (gnt),
    .rsp_o        (rsp),
    .crit_valid_o (crit_valid),
    .crit_word_o  (crit_word),
    .busy_o       (busy),
    .axi_req_o    (axi_req),
    .axi_rsp_i    (axi_rsp)
  );

  tb_axi_mem u_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .axi_req_i (axi_req),
    .axi_rsp_o (axi_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic [63:0] fill_word(int unsigned idx);
    return {32'(idx) * 32'h9e3779b9, 32'h5a5a0000 | 32'(idx)};
  endfunction

  function automatic ad_cfg_pkg::line_t random_line();
    ad_cfg_pkg::line_t r;
    for (int k = 0; k < 4; k++) r[k] = {$urandom, $urandom};
    return r;
  endfunction

  // line reads start at the line base; a single read only replaces word 0
  function automatic ad_cfg_pkg::line_t expected_line(txn_t t, ad_cfg_pkg::line_t prev);
    ad_cfg_pkg::line_t result;
    result = prev;
    if (t.is_line) begin
      for (int k = 0; k < 4; k++) result[k] = shadow[{t.addr[8:5], 2'(k)}];
    end else begin
      result[0] = shadow[t.addr[8:3]];
    end
    return result;
  endfunction

  task automatic check_eq(input logic [255:0] got, input logic [255:0] want,
                          input string what);
    if (got !== want) begin
      $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, want);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic run_txn(input logic we, input logic is_line, input logic [31:0] addr,
                         input logic [3:0] id);
    ad_cfg_pkg::line_t data;
    int unsigned       target;
    data            = random_line();
    target          = rsp_count + 1;
    cur_txn.we      = we;
    cur_txn.is_line = is_line;
    cur_txn.addr    = addr;
    cur_txn.id      = id;
    if (we && is_line) begin
      for (int k = 0; k < 4; k++) shadow[{addr[8:5], 2'(k)}] = data[k];
    end else if (we) begin
      shadow[addr[8:3]] = data[0];
    end
    // one idle cycle first, so busy is seen low between transactions
    repeat (2) @(posedge clk_i);
    #1;
    req            = 1'b1;
    req_data.addr  = addr;
    req_data.we    = we;
    req_data.kind  = is_line ? ad_cfg_pkg::REQ_LINE : ad_cfg_pkg::REQ_SINGLE;
    req_data.size  = 3'd3;
    req_data.id    = id;
    req_data.wdata = data;
    req_data.wstrb = '1;
    do @(negedge clk_i); while (!gnt);
    @(posedge clk_i);
    #1;
    req = 1'b0;
    wait (rsp_count == target);
  endtask

  initial begin
    void'($urandom(32'h4be9e2bc));
    rst_ni   = 1'b0;
    req      = 1'b0;
    req_data = '0;
    for (int i = 0; i < 64; i++) begin
      shadow[i]    = fill_word(i);
      u_mem.mem[i] = fill_word(i);
    end
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // single write, then single read of the same word
    run_txn(1'b1, 1'b0, 32'h48, 4'd3);
    run_txn(1'b0, 1'b0, 32'h48, 4'd5);
    // line write, then line reads at unaligned addresses inside it
    run_txn(1'b1, 1'b1, 32'h80, 4'd7);
    run_txn(1'b0, 1'b1, 32'h98, 4'd9);
    run_txn(1'b0, 1'b1, 32'h8c, 4'd2);
    repeat (N_RANDOM) begin
      run_txn(1'($urandom), 1'($urandom), 32'($urandom % 512), 4'($urandom));
    end

    // watch for stray responses before finishing
    repeat (DRAIN_CYCLES) @(posedge clk_i);
    $display("TESTBENCH PASSED");
    $finish;
  end

  // --------------------------------------------------
  // compare at the falling edge
  // --------------------------------------------------
  always @(negedge clk_i) begin
    txn_t              t;
    ad_cfg_pkg::line_t want;
    if (!rst_ni) begin
      check_eq(busy, 1'b0, "busy during reset");
    end else begin
      if (in_flight) check_eq(busy, 1'b1, "busy low while a request is in flight");
      else if (!req) check_eq(busy, 1'b0, "busy high between transactions");
      // a line write is one burst of four beats, a single write one beat
      if (axi_req.aw_valid && axi_rsp.aw_ready) begin
        check_eq(axi_req.aw.len, cur_txn.is_line ? 8'd3 : 8'd0, "AW burst length");
      end
      if (gnt) begin
        check_eq(req && !in_flight, 1'b1, "grant without a waiting request");
        pend_q.push_back(cur_txn);
        in_flight = 1'b1;
      end
      if (crit_valid) begin
        check_eq(pend_q.size() == 1 && !pend_q[0].we && pend_q[0].is_line, 1'b1,
                 "critical word outside a line read");
        t = pend_q[0];
        // word picked by addr[4:3] inside the line
        check_eq(crit_word, shadow[{t.addr[8:5], t.addr[4:3]}], "critical word");
        crit_count++;
      end
      if (rsp.valid) begin
        check_eq(pend_q.size(), 1, "response without an outstanding request");
        t = pend_q.pop_front();
        check_eq(rsp.id, t.id, "response id");
        if (!t.we) begin
          want = expected_line(t, prev_line);
          if (t.is_line || have_prev) check_eq(rsp.data, want, "read line");
          else check_eq(rsp.data[0], want[0], "read word 0");
          check_eq(crit_count, t.is_line ? 1 : 0, "critical word pulses");
          prev_line = rsp.data;
          have_prev = 1'b1;
        end
        crit_count = 0;
        in_flight  = 1'b0;
        rsp_count++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: %0d cycles passed with %0d of %0d responses",
               cycles, rsp_count, N_TRANS);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
ad_cfg_pkg.sv
ad_axi_pkg.sv
ad_write_ctrl.sv
ad_read_ctrl.sv
axi_line_adapter.sv
tb_axi_mem.sv
tb_axi_line_adapter.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_line_adapter
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check: run
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
